// File: logic/buffer_pkg.sv
`default_nettype none

package buffer_pkg;

	localparam int NUM_QUEUES = 4;
	localparam int QUEUE_DEPTH = 6;
	// above this depth the fullest queue wins, ties to the highest index
	localparam int QUEUE_THRESHOLD = 3;
	localparam int COUNT_W = 5;

	// raster in pixels and lines
	localparam int H_TOTAL = 800;
	localparam int H_SYNC = 96;
	localparam int H_VIS_START = 145;
	localparam int H_VIS_END = 783;
	localparam int V_TOTAL = 526;
	localparam int V_SYNC = 2;
	localparam int V_VIS_START = 36;
	localparam int V_VIS_END = 514;

	// slot blocks, one column per queue and one row per slot
	localparam int SLOT_SIZE = 36;
	localparam int COL_X [NUM_QUEUES] = '{200, 255, 315, 375};
	localparam int ROW_Y [QUEUE_DEPTH] = '{120, 165, 210, 255, 300, 345};

	typedef logic [1:0] qid_t;
	typedef logic [1:0] payload_t;
	typedef logic [2:0] qcount_t;
	typedef logic [7:0] color_t;

	typedef struct packed {
		qid_t dest;
		payload_t payload;
	} packet_t;

	typedef struct packed {
		logic valid;
		qid_t source;
		payload_t payload;
	} read_word_t;

	// slots[0] is the oldest entry
	typedef struct packed {
		qcount_t count;
		payload_t [QUEUE_DEPTH-1:0] slots;
	} queue_status_t;

	typedef struct packed {
		logic [COUNT_W-1:0] transmitted;
		logic [COUNT_W-1:0] received;
		logic [COUNT_W-1:0] dropped;
	} traffic_counts_t;

endpackage

`default_nettype wire

// File: logic/key_entry.sv
`default_nettype none

module key_entry (
	input wire clk,
	input wire reset_i,
	input wire key0_i,
	input wire key1_i,
	output logic pkt_valid_o,
	output buffer_pkg::packet_t pkt_o
);

	logic pressed;
	logic [1:0] bit_idx;
	logic [3:0] holder;
	logic pending;
	logic press_one;
	logic press_zero;

	// keys are active low, exactly one must be down
	assign press_one = !key0_i && key1_i;
	assign press_zero = key0_i && !key1_i;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			pressed <= 1'b0;
			bit_idx <= 2'd0;
			pending <= 1'b0;
			pkt_valid_o <= 1'b0;
		end else begin
			pkt_valid_o <= pending;
			pending <= 1'b0;
			if (key0_i && key1_i) begin
				pressed <= 1'b0;
			end else if (!pressed && (press_one || press_zero)) begin
				pressed <= 1'b1;
				bit_idx <= bit_idx + 2'd1;
				// fourth bit completes the packet
				if (bit_idx == 2'd3) begin
					pending <= 1'b1;
				end
			end
		end
	end

	// shift left so the first bit lands on top
	always_ff @(posedge clk) begin
		if (!pressed && (press_one || press_zero)) begin
			holder <= {holder[2:0], press_one};
		end
		if (pending) begin
			pkt_o.dest <= holder[3:2];
			pkt_o.payload <= holder[1:0];
		end
	end

endmodule

`default_nettype wire

// File: logic/packet_queue.sv
`default_nettype none

module packet_queue #(
	parameter buffer_pkg::qid_t QUEUE_ID = 2'd0
) (
	input wire clk,
	input wire reset_i,
	input wire pkt_valid_i,
	input wire buffer_pkg::packet_t pkt_i,
	input wire pop_i,
	output buffer_pkg::queue_status_t status_o,
	output logic drop_o,
	output logic accept_o
);

	buffer_pkg::payload_t [buffer_pkg::QUEUE_DEPTH-1:0] slots;
	buffer_pkg::qcount_t count;
	logic push_req;
	logic full;
	logic push;

	assign push_req = pkt_valid_i && (pkt_i.dest == QUEUE_ID);
	assign full = (count == buffer_pkg::qcount_t'(buffer_pkg::QUEUE_DEPTH));
	// full queue discards, even if a pop lands on the same edge
	assign push = push_req && !full;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			count <= '0;
			drop_o <= 1'b0;
			accept_o <= 1'b0;
		end else begin
			drop_o <= push_req && full;
			accept_o <= push;
			if (push && !pop_i) begin
				count <= count + 3'd1;
			end else if (pop_i && !push) begin
				count <= count - 3'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (pop_i) begin
			for (int i = 0; i < buffer_pkg::QUEUE_DEPTH - 1; i++) begin
				slots[i] <= slots[i+1];
			end
		end
		if (push) begin
			if (pop_i) begin
				slots[count - 3'd1] <= pkt_i.payload;
			end else begin
				slots[count] <= pkt_i.payload;
			end
		end
	end

	assign status_o.count = count;
	assign status_o.slots = slots;

	// the arbiter only serves queues that report entries
	assert property (@(posedge clk) disable iff (reset_i) pop_i |-> count != '0);

endmodule

`default_nettype wire

// File: logic/read_arbiter.sv
`default_nettype none

module read_arbiter #(
	parameter int unsigned READ_HOLD = 75_000_000
) (
	input wire clk,
	input wire reset_i,
	input wire read_i,
	input wire buffer_pkg::queue_status_t [buffer_pkg::NUM_QUEUES-1:0] status_i,
	output logic [buffer_pkg::NUM_QUEUES-1:0] pop_o,
	output buffer_pkg::read_word_t read_word_o
);

	logic [31:0] hold_cnt;
	logic fire;
	logic over;
	logic any;
	buffer_pkg::qid_t sel;
	buffer_pkg::qcount_t best;

	assign fire = read_i && (hold_cnt == READ_HOLD - 1);

	// pick the deepest queue; tie direction flips above threshold
	always_comb begin
		over = 1'b0;
		any = 1'b0;
		sel = '0;
		best = '0;
		for (int i = 0; i < buffer_pkg::NUM_QUEUES; i++) begin
			if (status_i[i].count > buffer_pkg::qcount_t'(buffer_pkg::QUEUE_THRESHOLD)) begin
				over = 1'b1;
			end
		end
		for (int i = 0; i < buffer_pkg::NUM_QUEUES; i++) begin
			if (status_i[i].count != '0) begin
				if (!any || status_i[i].count > best || (over && status_i[i].count == best)) begin
					sel = buffer_pkg::qid_t'(i);
					best = status_i[i].count;
				end
				any = 1'b1;
			end
		end
	end

	always_comb begin
		pop_o = '0;
		if (fire && any) begin
			pop_o[sel] = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			hold_cnt <= '0;
			read_word_o <= '0;
		end else begin
			if (!read_i || fire) begin
				hold_cnt <= '0;
			end else begin
				hold_cnt <= hold_cnt + 32'd1;
			end
			if (fire) begin
				if (any) begin
					read_word_o.valid <= 1'b1;
					read_word_o.source <= sel;
					read_word_o.payload <= status_i[sel].slots[0];
				end else begin
					// nothing queued this period
					read_word_o <= '0;
				end
			end
		end
	end

	assert property (@(posedge clk) disable iff (reset_i) $onehot0(pop_o));

endmodule

`default_nettype wire

// File: logic/traffic_stats.sv
`default_nettype none

module traffic_stats (
	input wire clk,
	input wire reset_i,
	input wire pkt_valid_i,
	input wire drop_i,
	input wire pop_i,
	output buffer_pkg::traffic_counts_t counts_o
);

	// counters wrap at 2**COUNT_W
	always_ff @(posedge clk) begin
		if (reset_i) begin
			counts_o <= '0;
		end else begin
			// every finished packet, dropped or not
			if (pkt_valid_i) begin
				counts_o.transmitted <= counts_o.transmitted + 1'b1;
			end
			if (pop_i) begin
				counts_o.received <= counts_o.received + 1'b1;
			end
			if (drop_i) begin
				counts_o.dropped <= counts_o.dropped + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/vga_timing.sv
`default_nettype none

module vga_timing (
	input wire clk,
	input wire reset_i,
	output logic pix_en_o,
	output logic [9:0] hcount_o,
	output logic [9:0] vcount_o,
	output logic visible_o,
	output logic hsync_o,
	output logic vsync_o
);

	// pixel rate is half of clk
	always_ff @(posedge clk) begin
		if (reset_i) begin
			pix_en_o <= 1'b0;
			hcount_o <= '0;
			vcount_o <= '0;
		end else begin
			pix_en_o <= !pix_en_o;
			if (pix_en_o) begin
				if (hcount_o == 10'(buffer_pkg::H_TOTAL - 1)) begin
					hcount_o <= '0;
					if (vcount_o == 10'(buffer_pkg::V_TOTAL - 1)) begin
						vcount_o <= '0;
					end else begin
						vcount_o <= vcount_o + 10'd1;
					end
				end else begin
					hcount_o <= hcount_o + 10'd1;
				end
			end
		end
	end

	assign hsync_o = hcount_o < 10'(buffer_pkg::H_SYNC);
	assign vsync_o = vcount_o < 10'(buffer_pkg::V_SYNC);
	assign visible_o = hcount_o >= 10'(buffer_pkg::H_VIS_START)
		&& hcount_o <= 10'(buffer_pkg::H_VIS_END)
		&& vcount_o >= 10'(buffer_pkg::V_VIS_START)
		&& vcount_o <= 10'(buffer_pkg::V_VIS_END);

	assert property (@(posedge clk) disable iff (reset_i)
		hcount_o < 10'(buffer_pkg::H_TOTAL) && vcount_o < 10'(buffer_pkg::V_TOTAL));

endmodule

`default_nettype wire

// File: logic/queue_display.sv
`default_nettype none

module queue_display (
	input wire clk,
	input wire reset_i,
	input wire pix_en_i,
	input wire [9:0] hcount_i,
	input wire [9:0] vcount_i,
	input wire visible_i,
	input wire buffer_pkg::queue_status_t [buffer_pkg::NUM_QUEUES-1:0] status_i,
	output buffer_pkg::color_t color_o
);

	logic [buffer_pkg::NUM_QUEUES-1:0] in_col;
	logic [buffer_pkg::QUEUE_DEPTH-1:0] in_row;
	buffer_pkg::color_t pixel;

	// colour is RRRGGGBB, payload sets brightness
	function automatic buffer_pkg::color_t slot_color(
		input buffer_pkg::qid_t q,
		input buffer_pkg::payload_t p
	);
		logic [2:0] lvl;
		lvl = {p, 1'b1};
		case (q)
			2'd0: return {lvl, 3'd0, 2'd0};
			2'd1: return {3'd0, 1'b0, p, 2'b11};
			2'd2: return {lvl, lvl, 2'd0};
			default: return {3'd0, lvl, 2'd0};
		endcase
	endfunction

	always_comb begin
		for (int q = 0; q < buffer_pkg::NUM_QUEUES; q++) begin
			in_col[q] = hcount_i >= 10'(buffer_pkg::COL_X[q])
				&& hcount_i < 10'(buffer_pkg::COL_X[q] + buffer_pkg::SLOT_SIZE);
		end
		for (int s = 0; s < buffer_pkg::QUEUE_DEPTH; s++) begin
			in_row[s] = vcount_i >= 10'(buffer_pkg::ROW_Y[s])
				&& vcount_i < 10'(buffer_pkg::ROW_Y[s] + buffer_pkg::SLOT_SIZE);
		end
	end

	// oldest entry sits in the top row
	always_comb begin
		pixel = '0;
		for (int q = 0; q < buffer_pkg::NUM_QUEUES; q++) begin
			for (int s = 0; s < buffer_pkg::QUEUE_DEPTH; s++) begin
				if (in_col[q] && in_row[s]) begin
					if (buffer_pkg::qcount_t'(s) < status_i[q].count) begin
						pixel = slot_color(buffer_pkg::qid_t'(q), status_i[q].slots[s]);
					end else begin
						// empty slot grey
						pixel = 8'h49;
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			color_o <= '0;
		end else if (pix_en_i) begin
			color_o <= visible_i ? pixel : '0;
		end
	end

endmodule

`default_nettype wire

// File: logic/packet_switch_top.sv
`default_nettype none

module packet_switch_top #(
	parameter int unsigned READ_HOLD = 75_000_000
) (
	input wire clk,
	input wire reset_i,
	input wire key0_i,
	input wire key1_i,
	input wire read_i,
	output logic hsync_o,
	output logic vsync_o,
	output buffer_pkg::color_t color_o,
	output buffer_pkg::read_word_t read_word_o,
	output buffer_pkg::traffic_counts_t counts_o
);

	logic pkt_valid;
	buffer_pkg::packet_t pkt;
	buffer_pkg::queue_status_t [buffer_pkg::NUM_QUEUES-1:0] status;
	logic [buffer_pkg::NUM_QUEUES-1:0] pop;
	logic [buffer_pkg::NUM_QUEUES-1:0] drop;
	logic [buffer_pkg::NUM_QUEUES-1:0] accept;
	logic pix_en;
	logic [9:0] hcount;
	logic [9:0] vcount;
	logic visible;

	key_entry u_key_entry (
		.clk(clk),
		.reset_i(reset_i),
		.key0_i(key0_i),
		.key1_i(key1_i),
		.pkt_valid_o(pkt_valid),
		.pkt_o(pkt)
	);

	// every queue sees the packet, only the addressed one takes it
	for (genvar g = 0; g < buffer_pkg::NUM_QUEUES; g++) begin : g_queue
		packet_queue #(
			.QUEUE_ID(buffer_pkg::qid_t'(g))
		) u_queue (
			.clk(clk),
			.reset_i(reset_i),
			.pkt_valid_i(pkt_valid),
			.pkt_i(pkt),
			.pop_i(pop[g]),
			.status_o(status[g]),
			.drop_o(drop[g]),
			.accept_o(accept[g])
		);
	end

	read_arbiter #(
		.READ_HOLD(READ_HOLD)
	) u_read_arbiter (
		.clk(clk),
		.reset_i(reset_i),
		.read_i(read_i),
		.status_i(status),
		.pop_o(pop),
		.read_word_o(read_word_o)
	);

	traffic_stats u_traffic_stats (
		.clk(clk),
		.reset_i(reset_i),
		.pkt_valid_i(pkt_valid),
		.drop_i(|drop),
		.pop_i(|pop),
		.counts_o(counts_o)
	);

	vga_timing u_vga_timing (
		.clk(clk),
		.reset_i(reset_i),
		.pix_en_o(pix_en),
		.hcount_o(hcount),
		.vcount_o(vcount),
		.visible_o(visible),
		.hsync_o(hsync_o),
		.vsync_o(vsync_o)
	);

	queue_display u_queue_display (
		.clk(clk),
		.reset_i(reset_i),
		.pix_en_i(pix_en),
		.hcount_i(hcount),
		.vcount_i(vcount),
		.visible_i(visible),
		.status_i(status),
		.color_o(color_o)
	);

	// each packet ends up in exactly one queue or is dropped by it
	assert property (@(posedge clk) disable iff (reset_i) pkt_valid |=> $onehot(accept | drop));

endmodule

`default_nettype wire

// File: verification/packet_switch_tb.sv
`default_nettype none

module packet_switch_tb;

	localparam int READ_HOLD = 20;
	localparam int WAIT_LIMIT = 200;
	localparam logic [31:0] SEED = 32'h45f1d955;

	logic clk;
	logic reset_i;
	logic key0_i;
	logic key1_i;
	logic read_i;
	logic hsync_o;
	logic vsync_o;
	buffer_pkg::color_t color_o;
	buffer_pkg::read_word_t read_word_o;
	buffer_pkg::traffic_counts_t counts_o;

	// reference queues and counters
	buffer_pkg::payload_t model_q [buffer_pkg::NUM_QUEUES][$];
	buffer_pkg::traffic_counts_t exp_counts;
	logic [31:0] lfsr_state;
	int errors;
	int tests_run;
	int tests_failed;

	packet_switch_top #(
		.READ_HOLD(READ_HOLD)
	) UUT (
		.clk(clk),
		.reset_i(reset_i),
		.key0_i(key0_i),
		.key1_i(key1_i),
		.read_i(read_i),
		.hsync_o(hsync_o),
		.vsync_o(vsync_o),
		.color_o(color_o),
		.read_word_o(read_word_o),
		.counts_o(counts_o)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h80200003;
		end else begin
			return s >> 1;
		end
	endfunction

	// one step per bit taken
	function automatic logic [1:0] random_pair();
		logic [1:0] r;
		r = '0;
		for (int i = 0; i < 2; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			r = {r[0], lfsr_state[0]};
		end
		return r;
	endfunction

	function automatic int total_queued();
		int n;
		n = 0;
		for (int i = 0; i < buffer_pkg::NUM_QUEUES; i++) begin
			n += model_q[i].size();
		end
		return n;
	endfunction

	// above threshold scan from the top so equal depths go to the higher index
	function automatic buffer_pkg::read_word_t expected_pop();
		bit deep;
		int best;
		int pick;
		int idx;
		buffer_pkg::read_word_t w;
		deep = 1'b0;
		best = 0;
		pick = -1;
		w = '0;
		for (int i = 0; i < buffer_pkg::NUM_QUEUES; i++) begin
			if (model_q[i].size() > buffer_pkg::QUEUE_THRESHOLD) begin
				deep = 1'b1;
			end
		end
		for (int k = 0; k < buffer_pkg::NUM_QUEUES; k++) begin
			idx = deep ? buffer_pkg::NUM_QUEUES - 1 - k : k;
			if (model_q[idx].size() > best) begin
				best = model_q[idx].size();
				pick = idx;
			end
		end
		if (pick >= 0) begin
			w.valid = 1'b1;
			w.source = buffer_pkg::qid_t'(pick);
			w.payload = model_q[pick][0];
		end
		return w;
	endfunction

	task automatic compare_read(input string name, input buffer_pkg::read_word_t got,
		input buffer_pkg::read_word_t exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got v=%b q=%0d p=%0d, expected v=%b q=%0d p=%0d",
				$time, name, got.valid, got.source, got.payload,
				exp.valid, exp.source, exp.payload);
			errors++;
		end
	endtask

	task automatic compare_counts(input string name, input buffer_pkg::traffic_counts_t got,
		input buffer_pkg::traffic_counts_t exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s (tx/rx/drop) got %0d/%0d/%0d, expected %0d/%0d/%0d",
				$time, name, got.transmitted, got.received, got.dropped,
				exp.transmitted, exp.received, exp.dropped);
			errors++;
		end
	endtask

	task automatic compare_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %b, expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic compare_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("Mismatch at %0t: %s got %0d, expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	// key0 low enters a 1, key1 low a 0
	task automatic press_key(input logic value);
		@(posedge clk);
		if (value) begin
			key0_i <= 1'b0;
		end else begin
			key1_i <= 1'b0;
		end
		repeat (3) @(posedge clk);
		key0_i <= 1'b1;
		key1_i <= 1'b1;
		repeat (3) @(posedge clk);
	endtask

	task automatic send_packet(input buffer_pkg::qid_t dest, input buffer_pkg::payload_t payload);
		press_key(dest[1]);
		press_key(dest[0]);
		press_key(payload[1]);
		press_key(payload[0]);
		exp_counts.transmitted = exp_counts.transmitted + 5'd1;
		if (model_q[dest].size() < buffer_pkg::QUEUE_DEPTH) begin
			model_q[dest].push_back(payload);
		end else begin
			exp_counts.dropped = exp_counts.dropped + 5'd1;
		end
	endtask

	task automatic read_and_check(input string name);
		buffer_pkg::read_word_t exp;
		logic [buffer_pkg::COUNT_W-1:0] start;
		int waited;
		exp = expected_pop();
		start = counts_o.received;
		waited = 0;
		@(posedge clk);
		read_i <= 1'b1;
		@(negedge clk);
		while (counts_o.received == start && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		@(posedge clk);
		read_i <= 1'b0;
		if (counts_o.received == start) begin
			$display("%s: no packet was popped while read was held", name);
			errors++;
		end else begin
			compare_read(name, read_word_o, exp);
			void'(model_q[exp.source].pop_front());
			exp_counts.received = exp_counts.received + 5'd1;
		end
		@(negedge clk);
	endtask

	task automatic drain_queues(input string name);
		for (int n = 0; n < 30 && total_queued() > 0; n++) begin
			read_and_check(name);
		end
		compare_counts({name, " counts_o"}, counts_o, exp_counts);
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, errors - errors_before);
		end
	endtask

	task automatic test_reset_state();
		int e;
		e = errors;
		compare_read("read_word_o", read_word_o, '0);
		compare_counts("counts_o", counts_o, '0);
		compare_bit("hsync_o", hsync_o, 1'b1);
		compare_bit("vsync_o", vsync_o, 1'b1);
		finish_test("reset_state", e);
	endtask

	task automatic test_single_packet();
		int e;
		e = errors;
		send_packet(2'd2, 2'd1);
		compare_counts("counts_o", counts_o, exp_counts);
		read_and_check("read_word_o");
		compare_counts("counts_o", counts_o, exp_counts);
		finish_test("single_packet", e);
	endtask

	task automatic test_random_low();
		int e;
		int sent;
		buffer_pkg::qid_t dest;
		buffer_pkg::payload_t payload;
		e = errors;
		sent = 0;
		while (sent < 7) begin
			dest = random_pair();
			payload = random_pair();
			if (model_q[dest].size() < buffer_pkg::QUEUE_THRESHOLD) begin
				send_packet(dest, payload);
				sent++;
			end
		end
		drain_queues("read_word_o");
		finish_test("random_below_threshold", e);
	endtask

	task automatic test_threshold();
		int e;
		e = errors;
		for (int i = 0; i < 5; i++) begin
			send_packet(2'd1, random_pair());
		end
		for (int i = 0; i < 2; i++) begin
			send_packet(2'd3, random_pair());
		end
		drain_queues("read_word_o");
		// equal depths above threshold go to the higher index first
		for (int i = 0; i < 4; i++) begin
			send_packet(2'd0, random_pair());
			send_packet(2'd2, random_pair());
		end
		drain_queues("read_word_o");
		finish_test("above_threshold", e);
	endtask

	task automatic test_overflow();
		int e;
		e = errors;
		for (int i = 0; i < 7; i++) begin
			send_packet(2'd2, random_pair());
		end
		compare_counts("counts_o", counts_o, exp_counts);
		compare_count("dropped", int'(counts_o.dropped), 1);
		drain_queues("read_word_o");
		finish_test("overflow_drop", e);
	endtask

	task automatic test_empty_read();
		int e;
		int waited;
		e = errors;
		waited = 0;
		@(posedge clk);
		read_i <= 1'b1;
		@(negedge clk);
		while (read_word_o.valid && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		@(posedge clk);
		read_i <= 1'b0;
		if (read_word_o.valid) begin
			$display("empty read: valid never cleared after a hold period");
			errors++;
		end else begin
			compare_read("read_word_o", read_word_o, '0);
			compare_counts("counts_o", counts_o, exp_counts);
		end
		finish_test("empty_read", e);
	endtask

	// one full line is two clk cycles per pixel
	task automatic test_hsync();
		int e;
		int high_cycles;
		e = errors;
		high_cycles = 0;
		for (int i = 0; i < 2 * buffer_pkg::H_TOTAL; i++) begin
			@(negedge clk);
			if (hsync_o) begin
				high_cycles++;
				compare_bit("color_o zero in hsync", color_o == '0, 1'b1);
			end
		end
		compare_count("hsync_o high cycles", high_cycles, 2 * buffer_pkg::H_SYNC);
		finish_test("hsync_timing", e);
	endtask

	initial begin
		reset_i = 1'b1;
		key0_i = 1'b1;
		key1_i = 1'b1;
		read_i = 1'b0;
		lfsr_state = SEED;
		exp_counts = '0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		repeat (2) @(posedge clk);
		reset_i <= 1'b0;
		@(negedge clk);
		test_reset_state();
		test_single_packet();
		test_random_low();
		test_threshold();
		test_overflow();
		test_empty_read();
		test_hsync();
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
logic/buffer_pkg.sv
logic/key_entry.sv
logic/packet_queue.sv
logic/read_arbiter.sv
logic/traffic_stats.sv
logic/vga_timing.sv
logic/queue_display.sv
logic/packet_switch_top.sv
verification/packet_switch_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= packet_switch_tb
FILELIST ?= all.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
SIM ?= $(OBJ_DIR)/V$(TOP)

SRCS := $(wildcard logic/*.sv) $(wildcard verification/*.sv)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
